// ==== hdl/decode_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction-set widths, opcode and select enums, flushed-insn constant
////////////////////////////////////////////////////////////////////////////
package decode_pkg;

	// instruction, pc and immediate word
	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_addr_t;
	// word-aligned branch target
	typedef logic [31:2] target_t;
	// sfxx condition, insn[24:21]
	typedef logic [3:0] comp_op_t;
	// shift/rotate sub-field, insn[9:6]
	typedef logic [3:0] alu_op2_t;

	// major opcodes, insn[31:26]
	typedef enum logic [5:0] {
		OP_J = 6'h00, OP_JAL = 6'h01, OP_BNF = 6'h03, OP_BF = 6'h04,
		OP_NOP = 6'h05, OP_MOVHI = 6'h06, OP_XSYNC = 6'h08, OP_RFE = 6'h09,
		OP_JR = 6'h11, OP_JALR = 6'h12,
		OP_LWZ = 6'h21, OP_LWS = 6'h22, OP_LBZ = 6'h23, OP_LBS = 6'h24,
		OP_LHZ = 6'h25, OP_LHS = 6'h26,
		OP_ADDI = 6'h27, OP_ADDIC = 6'h28, OP_ANDI = 6'h29, OP_ORI = 6'h2a,
		OP_XORI = 6'h2b, OP_MULI = 6'h2c, OP_MFSPR = 6'h2d, OP_SH_ROTI = 6'h2e,
		OP_SFXXI = 6'h2f, OP_MTSPR = 6'h30,
		OP_SW = 6'h35, OP_SB = 6'h36, OP_SH = 6'h37,
		OP_ALU = 6'h38, OP_SFXX = 6'h39
	} opcode_e;

	// alu ops, low half follows the isa sub-op field
	typedef enum logic [4:0] {
		ALU_ADD = 5'h00, ALU_ADDC = 5'h01, ALU_SUB = 5'h02, ALU_AND = 5'h03,
		ALU_OR = 5'h04, ALU_XOR = 5'h05, ALU_MUL = 5'h06, ALU_SHROT = 5'h08,
		ALU_DIV = 5'h09, ALU_DIVU = 5'h0a, ALU_MULU = 5'h0b, ALU_EXTHB = 5'h0c,
		ALU_EXTW = 5'h0d, ALU_CMOV = 5'h0e, ALU_FFL1 = 5'h0f,
		// decoder-only ops
		ALU_MOVHI = 5'h10, ALU_COMP = 5'h11,
		// idle, outside the sub-op space
		ALU_NOP = 5'h1f
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NOP = 3'd0, BR_J = 3'd1, BR_JR = 3'd2,
		BR_BF = 3'd4, BR_BNF = 3'd5, BR_RFE = 3'd6
	} branch_op_e;

	typedef enum logic [3:0] {
		LSU_NOP = 4'b0000,
		LSU_LBZ = 4'b0010, LSU_LBS = 4'b0011, LSU_LHZ = 4'b0100,
		LSU_LHS = 4'b0101, LSU_LWZ = 4'b0110, LSU_LWS = 4'b0111,
		LSU_SB = 4'b1010, LSU_SH = 4'b1100, LSU_SW = 4'b1110
	} lsu_op_e;

	// write-back mux source
	typedef enum logic [2:0] {
		RFWB_ALU = 3'd0, RFWB_LSU = 3'd1, RFWB_SPRS = 3'd2, RFWB_LR = 3'd3
	} rfwb_src_e;

	// operand mux select
	typedef enum logic [1:0] {
		SEL_RF = 2'd0, SEL_IMM = 2'd1, SEL_EX_FORW = 2'd2, SEL_WB_FORW = 2'd3
	} sel_e;

	// l.nop with bit 16 set marks a flushed slot
	localparam word_t NOP_INSN = {OP_NOP, 26'h041_0000};
	// jal/jalr link register
	localparam reg_addr_t LINK_REG = 5'd9;

endpackage

// ==== hdl/insn_pipe.sv ====
////////////////////////////////////////////////////////////////////////////
// ID, EX and WB instruction latches with flush and bubble
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module insn_pipe (
	input  logic              clk,
	input  logic              rst,
	input  logic              id_freeze,
	input  logic              ex_freeze,
	input  logic              wb_freeze,
	input  logic              flushpipe,
	input  decode_pkg::word_t if_insn,
	output decode_pkg::word_t id_insn,
	output decode_pkg::word_t ex_insn,
	output decode_pkg::word_t wb_insn
);
	import decode_pkg::*;

	logic ex_bubble;

	// EX runs on while ID is stuck, or whole pipe flushed
	assign ex_bubble = (!ex_freeze && id_freeze) || flushpipe;

	// ID latch
	always_ff @(posedge clk) begin
		if (rst || flushpipe) begin
			id_insn <= NOP_INSN;
		end else if (!id_freeze) begin
			id_insn <= if_insn;
		end
	end

	// EX latch
	always_ff @(posedge clk) begin
		if (rst || ex_bubble) begin
			ex_insn <= NOP_INSN;
		end else if (!ex_freeze) begin
			ex_insn <= id_insn;
		end
	end

	// WB latch, not flushed so the retired record stays exact
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_insn <= NOP_INSN;
		end else if (!wb_freeze) begin
			wb_insn <= ex_insn;
		end
	end

endmodule

// ==== hdl/if_predecode.sv ====
////////////////////////////////////////////////////////////////////////////
// IF-stage predecode of branch class and immediate select
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module if_predecode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   id_freeze,
	input  logic                   flushpipe,
	input  decode_pkg::word_t      if_insn,
	output decode_pkg::branch_op_e id_branch_op,
	output logic                   sel_imm
);
	import decode_pkg::*;

	opcode_e if_opc;

	assign if_opc = opcode_e'(if_insn[31:26]);

	// branch class, one stage ahead of id_insn
	always_ff @(posedge clk) begin
		if (rst || flushpipe) begin
			id_branch_op <= BR_NOP;
		end else if (!id_freeze) begin
			case (if_opc)
				OP_J, OP_JAL:   id_branch_op <= BR_J;
				OP_JR, OP_JALR: id_branch_op <= BR_JR;
				OP_BF:          id_branch_op <= BR_BF;
				OP_BNF:         id_branch_op <= BR_BNF;
				OP_RFE:         id_branch_op <= BR_RFE;
				default:        id_branch_op <= BR_NOP;
			endcase
		end
	end

	// operand b from the immediate
	// flush leaves it alone, only id_freeze holds it
	always_ff @(posedge clk) begin
		if (rst) begin
			sel_imm <= 1'b0;
		end else if (!id_freeze) begin
			case (if_opc)
				// register-register and no-operand forms
				OP_JALR, OP_JR, OP_RFE, OP_MFSPR, OP_MTSPR, OP_XSYNC,
				OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX, OP_NOP:
					sel_imm <= 1'b0;
				default:
					sel_imm <= 1'b1;
			endcase
		end
	end

endmodule

// ==== hdl/imm_branch_gen.sv ====
////////////////////////////////////////////////////////////////////////////
// immediate extension and branch target, ID values and EX copies
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module imm_branch_gen (
	input  logic                clk,
	input  logic                rst,
	input  logic                ex_freeze,
	input  decode_pkg::word_t   id_insn,
	input  decode_pkg::word_t   id_pc,
	output decode_pkg::word_t   id_simm,
	output decode_pkg::word_t   ex_simm,
	output decode_pkg::target_t id_branch_addrtarget,
	output decode_pkg::target_t ex_branch_addrtarget
);
	import decode_pkg::*;

	opcode_e id_opc;

	assign id_opc = opcode_e'(id_insn[31:26]);

	// id immediate
	always_comb begin
		case (id_opc)
			// signed 16-bit forms
			OP_ADDI, OP_ADDIC, OP_XORI, OP_SFXXI,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				id_simm = {{16{id_insn[15]}}, id_insn[15:0]};
			// split field, spr number offset
			OP_MTSPR:
				id_simm = {16'b0, id_insn[25:21], id_insn[10:0]};
			// split field, signed store offset
			OP_SW, OP_SB, OP_SH:
				id_simm = {{16{id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {16'b0, id_insn[15:0]};
		endcase
	end

	// pc-relative target in words, 26-bit signed offset
	assign id_branch_addrtarget = {{4{id_insn[25]}}, id_insn[25:0]} + id_pc[31:2];

	// ex copies, follow ex_freeze only
	always_ff @(posedge clk) begin
		if (rst) begin
			ex_simm <= '0;
			ex_branch_addrtarget <= '0;
		end else if (!ex_freeze) begin
			ex_simm <= id_simm;
			ex_branch_addrtarget <= id_branch_addrtarget;
		end
	end

endmodule

// ==== hdl/ex_ctrl_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// EX-stage control fields, exceptions, write address; ID lsu op
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module ex_ctrl_decode (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   id_freeze,
	input  logic                   ex_freeze,
	input  logic                   flushpipe,
	input  decode_pkg::word_t      id_insn,
	input  decode_pkg::branch_op_e id_branch_op,
	output decode_pkg::alu_op_e    alu_op,
	output decode_pkg::alu_op2_t   alu_op2,
	output decode_pkg::comp_op_t   comp_op,
	output decode_pkg::rfwb_src_e  rfwb_src,
	output logic                   rfwb_we,
	output decode_pkg::reg_addr_t  rf_addrw,
	output decode_pkg::branch_op_e ex_branch_op,
	output logic                   spr_read,
	output logic                   spr_write,
	output logic                   sig_syscall,
	output logic                   sig_trap,
	output logic                   except_illegal,
	output decode_pkg::lsu_op_e    id_lsu_op
);
	import decode_pkg::*;

	opcode_e   id_opc;
	alu_op_e   dec_alu_op;
	rfwb_src_e dec_rfwb_src;
	logic      dec_rfwb_we;
	logic      dec_illegal;
	reg_addr_t dec_addrw;
	logic      ex_bubble;

	assign id_opc = opcode_e'(id_insn[31:26]);
	assign ex_bubble = (!ex_freeze && id_freeze) || flushpipe;

	// link writes go to r9
	assign dec_addrw = (id_opc == OP_JAL || id_opc == OP_JALR) ? LINK_REG : id_insn[25:21];

	////////////////////////////////////////////////////////////////////////////
	// id-side decode
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (id_opc)
			OP_MOVHI:         dec_alu_op = ALU_MOVHI;
			OP_ADDI:          dec_alu_op = ALU_ADD;
			OP_ADDIC:         dec_alu_op = ALU_ADDC;
			OP_ANDI:          dec_alu_op = ALU_AND;
			OP_ORI:           dec_alu_op = ALU_OR;
			OP_XORI:          dec_alu_op = ALU_XOR;
			OP_SH_ROTI:       dec_alu_op = ALU_SHROT;
			OP_SFXX, OP_SFXXI: dec_alu_op = ALU_COMP;
			// sub-op field straight through
			OP_ALU:           dec_alu_op = alu_op_e'({1'b0, id_insn[3:0]});
			default:          dec_alu_op = ALU_NOP;
		endcase
	end

	// write-back source and enable
	always_comb begin
		dec_rfwb_we = 1'b1;
		case (id_opc)
			OP_JAL, OP_JALR: dec_rfwb_src = RFWB_LR;
			OP_MFSPR:        dec_rfwb_src = RFWB_SPRS;
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				dec_rfwb_src = RFWB_LSU;
			OP_MOVHI, OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI,
			OP_SH_ROTI, OP_ALU:
				dec_rfwb_src = RFWB_ALU;
			default: begin
				dec_rfwb_src = RFWB_ALU;
				dec_rfwb_we = 1'b0;
			end
		endcase
	end

	// no mul/div unit in this core so those sub-ops are illegal too
	always_comb begin
		case (id_opc)
			OP_J, OP_JAL, OP_JALR, OP_JR, OP_BNF, OP_BF, OP_RFE, OP_NOP,
			OP_MOVHI, OP_MFSPR, OP_MTSPR, OP_XSYNC,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS,
			OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI, OP_SH_ROTI,
			OP_SFXXI, OP_SFXX, OP_SW, OP_SB, OP_SH:
				dec_illegal = 1'b0;
			OP_ALU:
				dec_illegal = (dec_alu_op == ALU_MUL) || (dec_alu_op == ALU_MULU) ||
					(dec_alu_op == ALU_DIV) || (dec_alu_op == ALU_DIVU);
			// includes l.muli
			default:
				dec_illegal = 1'b1;
		endcase
	end

	// lsu op consumed in ID
	always_comb begin
		case (id_opc)
			OP_LWZ:  id_lsu_op = LSU_LWZ;
			OP_LWS:  id_lsu_op = LSU_LWS;
			OP_LBZ:  id_lsu_op = LSU_LBZ;
			OP_LBS:  id_lsu_op = LSU_LBS;
			OP_LHZ:  id_lsu_op = LSU_LHZ;
			OP_LHS:  id_lsu_op = LSU_LHS;
			OP_SW:   id_lsu_op = LSU_SW;
			OP_SB:   id_lsu_op = LSU_SB;
			OP_SH:   id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// ex registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (rst || ex_bubble) begin
			alu_op <= ALU_NOP;
			alu_op2 <= '0;
			comp_op <= '0;
			rfwb_src <= RFWB_ALU;
			rfwb_we <= 1'b0;
			rf_addrw <= '0;
			ex_branch_op <= BR_NOP;
			spr_read <= 1'b0;
			spr_write <= 1'b0;
			sig_syscall <= 1'b0;
			sig_trap <= 1'b0;
			except_illegal <= 1'b0;
		end else if (!ex_freeze) begin
			alu_op <= dec_alu_op;
			alu_op2 <= id_insn[9:6];
			comp_op <= id_insn[24:21];
			rfwb_src <= dec_rfwb_src;
			rfwb_we <= dec_rfwb_we;
			rf_addrw <= dec_addrw;
			ex_branch_op <= id_branch_op;
			spr_read <= (id_opc == OP_MFSPR);
			spr_write <= (id_opc == OP_MTSPR);
			// l.sys and l.trap share xsync and split on insn[25:23]
			sig_syscall <= (id_insn[31:23] == {OP_XSYNC, 3'b000});
			sig_trap <= (id_insn[31:23] == {OP_XSYNC, 3'b010});
			except_illegal <= dec_illegal;
		end
	end

endmodule

// ==== hdl/operand_fwd.sv ====
////////////////////////////////////////////////////////////////////////////
// WB write address and forwarding selects for operands A and B
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module operand_fwd (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  wb_freeze,
	input  decode_pkg::word_t     id_insn,
	input  logic                  sel_imm,
	input  decode_pkg::reg_addr_t rf_addrw,
	input  logic                  rfwb_we,
	input  logic                  wbforw_valid,
	output decode_pkg::sel_e      sel_a,
	output decode_pkg::sel_e      sel_b
);
	import decode_pkg::*;

	reg_addr_t wb_rfaddrw;

	// write address one stage behind EX
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_rfaddrw <= '0;
		end else if (!wb_freeze) begin
			wb_rfaddrw <= rf_addrw;
		end
	end

	// EX result beats WB result, RF last
	always_comb begin
		if (id_insn[20:16] == rf_addrw && rfwb_we) begin
			sel_a = SEL_EX_FORW;
		end else if (id_insn[20:16] == wb_rfaddrw && wbforw_valid) begin
			sel_a = SEL_WB_FORW;
		end else begin
			sel_a = SEL_RF;
		end
	end

	// immediate overrides any match on rB
	always_comb begin
		if (sel_imm) begin
			sel_b = SEL_IMM;
		end else if (id_insn[15:11] == rf_addrw && rfwb_we) begin
			sel_b = SEL_EX_FORW;
		end else if (id_insn[15:11] == wb_rfaddrw && wbforw_valid) begin
			sel_b = SEL_WB_FORW;
		end else begin
			sel_b = SEL_RF;
		end
	end

endmodule

// ==== hdl/ctrl_top.sv ====
////////////////////////////////////////////////////////////////////////////
// decode and pipeline control top, flush forming and stage wiring
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module ctrl_top (
	input  logic                   clk,
	input  logic                   rst,
	// pipeline control
	input  logic                   id_freeze,
	input  logic                   ex_freeze,
	input  logic                   wb_freeze,
	input  logic                   except_flushpipe,
	input  logic                   pc_we,
	input  logic                   extend_flush,
	input  logic                   wbforw_valid,
	output logic                   flushpipe,
	// fetch side
	input  decode_pkg::word_t      if_insn,
	input  decode_pkg::word_t      id_pc,
	output decode_pkg::reg_addr_t  rf_addra,
	output decode_pkg::reg_addr_t  rf_addrb,
	// instruction latches
	output decode_pkg::word_t      id_insn,
	output decode_pkg::word_t      ex_insn,
	output decode_pkg::word_t      wb_insn,
	// id outputs
	output decode_pkg::branch_op_e id_branch_op,
	output decode_pkg::lsu_op_e    id_lsu_op,
	output decode_pkg::word_t      id_simm,
	output decode_pkg::target_t    id_branch_addrtarget,
	output decode_pkg::sel_e       sel_a,
	output decode_pkg::sel_e       sel_b,
	// ex outputs
	output decode_pkg::word_t      ex_simm,
	output decode_pkg::target_t    ex_branch_addrtarget,
	output decode_pkg::branch_op_e ex_branch_op,
	output decode_pkg::alu_op_e    alu_op,
	output decode_pkg::alu_op2_t   alu_op2,
	output decode_pkg::comp_op_t   comp_op,
	output decode_pkg::rfwb_src_e  rfwb_src,
	output logic                   rfwb_we,
	output decode_pkg::reg_addr_t  rf_addrw,
	output logic                   spr_read,
	output logic                   spr_write,
	output logic                   sig_syscall,
	output logic                   sig_trap,
	output logic                   except_illegal
);

	logic sel_imm;

	// one flush for every stage
	assign flushpipe = except_flushpipe || pc_we || extend_flush;

	// rf read ports addressed straight from fetch
	assign rf_addra = if_insn[20:16];
	assign rf_addrb = if_insn[15:11];

	insn_pipe insn_pipe_i (
		.clk       (clk),
		.rst       (rst),
		.id_freeze (id_freeze),
		.ex_freeze (ex_freeze),
		.wb_freeze (wb_freeze),
		.flushpipe (flushpipe),
		.if_insn   (if_insn),
		.id_insn   (id_insn),
		.ex_insn   (ex_insn),
		.wb_insn   (wb_insn)
	);

	if_predecode if_predecode_i (
		.clk          (clk),
		.rst          (rst),
		.id_freeze    (id_freeze),
		.flushpipe    (flushpipe),
		.if_insn      (if_insn),
		.id_branch_op (id_branch_op),
		.sel_imm      (sel_imm)
	);

	imm_branch_gen imm_branch_gen_i (
		.clk                  (clk),
		.rst                  (rst),
		.ex_freeze            (ex_freeze),
		.id_insn              (id_insn),
		.id_pc                (id_pc),
		.id_simm              (id_simm),
		.ex_simm              (ex_simm),
		.id_branch_addrtarget (id_branch_addrtarget),
		.ex_branch_addrtarget (ex_branch_addrtarget)
	);

	ex_ctrl_decode ex_ctrl_decode_i (
		.clk            (clk),
		.rst            (rst),
		.id_freeze      (id_freeze),
		.ex_freeze      (ex_freeze),
		.flushpipe      (flushpipe),
		.id_insn        (id_insn),
		.id_branch_op   (id_branch_op),
		.alu_op         (alu_op),
		.alu_op2        (alu_op2),
		.comp_op        (comp_op),
		.rfwb_src       (rfwb_src),
		.rfwb_we        (rfwb_we),
		.rf_addrw       (rf_addrw),
		.ex_branch_op   (ex_branch_op),
		.spr_read       (spr_read),
		.spr_write      (spr_write),
		.sig_syscall    (sig_syscall),
		.sig_trap       (sig_trap),
		.except_illegal (except_illegal),
		.id_lsu_op      (id_lsu_op)
	);

	// forwarding compares ID sources against EX and WB destinations
	operand_fwd operand_fwd_i (
		.clk          (clk),
		.rst          (rst),
		.wb_freeze    (wb_freeze),
		.id_insn      (id_insn),
		.sel_imm      (sel_imm),
		.rf_addrw     (rf_addrw),
		.rfwb_we      (rfwb_we),
		.wbforw_valid (wbforw_valid),
		.sel_a        (sel_a),
		.sel_b        (sel_b)
	);

endmodule

// ==== dv/tb_ctrl.sv ====
////////////////////////////////////////////////////////////////////////////
// ctrl_top testbench with stimulus, pipeline reference model and checks
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns

module tb_ctrl;
	import decode_pkg::*;

	// cycle counts of the directed and random parts
	localparam int DIRECTED_CYCLES = 160;
	localparam int RAND_CYCLES = 600;
	localparam int MAX_CYCLES = 4 * (DIRECTED_CYCLES + RAND_CYCLES) + 50;

	logic       clk;
	logic       rst;
	logic       id_freeze;
	logic       ex_freeze;
	logic       wb_freeze;
	logic       except_flushpipe;
	logic       pc_we;
	logic       extend_flush;
	logic       wbforw_valid;
	logic       flushpipe;
	word_t      if_insn;
	word_t      id_pc;
	reg_addr_t  rf_addra;
	reg_addr_t  rf_addrb;
	word_t      id_insn;
	word_t      ex_insn;
	word_t      wb_insn;
	branch_op_e id_branch_op;
	lsu_op_e    id_lsu_op;
	word_t      id_simm;
	target_t    id_branch_addrtarget;
	sel_e       sel_a;
	sel_e       sel_b;
	word_t      ex_simm;
	target_t    ex_branch_addrtarget;
	branch_op_e ex_branch_op;
	alu_op_e    alu_op;
	alu_op2_t   alu_op2;
	comp_op_t   comp_op;
	rfwb_src_e  rfwb_src;
	logic       rfwb_we;
	reg_addr_t  rf_addrw;
	logic       spr_read;
	logic       spr_write;
	logic       sig_syscall;
	logic       sig_trap;
	logic       except_illegal;

	// reference pipeline state
	word_t     m_id_insn;
	word_t     m_ex_insn;
	word_t     m_wb_insn;
	logic      m_ex_valid;
	logic      m_sel_imm;
	word_t     m_ex_simm;
	target_t   m_ex_tgt;
	reg_addr_t m_wb_addrw;

	string       test_name = "reset";
	logic [15:0] lfsr_q;
	int          cycle_cnt = 0;

	ctrl_top dut_i (.*);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// expected decode from the isa tables
	////////////////////////////////////////////////////////////////////////////

	function automatic branch_op_e predecode_branch(word_t insn);
		case (opcode_e'(insn[31:26]))
			OP_J, OP_JAL:   return BR_J;
			OP_JR, OP_JALR: return BR_JR;
			OP_BF:          return BR_BF;
			OP_BNF:         return BR_BNF;
			OP_RFE:         return BR_RFE;
			default:        return BR_NOP;
		endcase
	endfunction

	// operand b from immediate unless reg-reg or no-operand form
	function automatic logic predecode_sel_imm(word_t insn);
		case (opcode_e'(insn[31:26]))
			OP_JALR, OP_JR, OP_RFE, OP_MFSPR, OP_MTSPR, OP_XSYNC,
			OP_SW, OP_SB, OP_SH, OP_ALU, OP_SFXX, OP_NOP:
				return 1'b0;
			default:
				return 1'b1;
		endcase
	endfunction

	function automatic word_t extend_imm(word_t insn);
		case (opcode_e'(insn[31:26]))
			OP_ADDI, OP_ADDIC, OP_XORI, OP_SFXXI,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				return {{16{insn[15]}}, insn[15:0]};
			OP_MTSPR:
				return {16'h0000, insn[25:21], insn[10:0]};
			// stores sign-extend the split offset
			OP_SW, OP_SB, OP_SH:
				return {{16{insn[25]}}, insn[25:21], insn[10:0]};
			default:
				return {16'h0000, insn[15:0]};
		endcase
	endfunction

	function automatic target_t branch_target(word_t insn, word_t pc);
		logic [29:0] offs;
		offs = {{4{insn[25]}}, insn[25:0]};
		return offs + pc[31:2];
	endfunction

	function automatic lsu_op_e lsu_of(word_t insn);
		case (opcode_e'(insn[31:26]))
			OP_LWZ:  return LSU_LWZ;
			OP_LWS:  return LSU_LWS;
			OP_LBZ:  return LSU_LBZ;
			OP_LBS:  return LSU_LBS;
			OP_LHZ:  return LSU_LHZ;
			OP_LHS:  return LSU_LHS;
			OP_SW:   return LSU_SW;
			OP_SB:   return LSU_SB;
			OP_SH:   return LSU_SH;
			default: return LSU_NOP;
		endcase
	endfunction

	function automatic alu_op_e alu_of(word_t insn);
		case (opcode_e'(insn[31:26]))
			OP_MOVHI:          return ALU_MOVHI;
			OP_ADDI:           return ALU_ADD;
			OP_ADDIC:          return ALU_ADDC;
			OP_ANDI:           return ALU_AND;
			OP_ORI:            return ALU_OR;
			OP_XORI:           return ALU_XOR;
			OP_SH_ROTI:        return ALU_SHROT;
			OP_SFXX, OP_SFXXI: return ALU_COMP;
			OP_ALU:            return alu_op_e'({1'b0, insn[3:0]});
			default:           return ALU_NOP;
		endcase
	endfunction

	function automatic rfwb_src_e wb_src_of(word_t insn);
		case (opcode_e'(insn[31:26]))
			OP_JAL, OP_JALR: return RFWB_LR;
			OP_MFSPR:        return RFWB_SPRS;
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS:
				return RFWB_LSU;
			default:         return RFWB_ALU;
		endcase
	endfunction

	// opcodes that write a register
	function automatic logic wb_we_of(word_t insn);
		case (opcode_e'(insn[31:26]))
			OP_JAL, OP_JALR, OP_MFSPR,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS,
			OP_MOVHI, OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI,
			OP_SH_ROTI, OP_ALU:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic illegal_of(word_t insn);
		logic [4:0] sub;
		sub = {1'b0, insn[3:0]};
		case (opcode_e'(insn[31:26]))
			OP_J, OP_JAL, OP_JALR, OP_JR, OP_BNF, OP_BF, OP_RFE, OP_NOP,
			OP_MOVHI, OP_MFSPR, OP_MTSPR, OP_XSYNC,
			OP_LWZ, OP_LWS, OP_LBZ, OP_LBS, OP_LHZ, OP_LHS,
			OP_ADDI, OP_ADDIC, OP_ANDI, OP_ORI, OP_XORI, OP_SH_ROTI,
			OP_SFXXI, OP_SFXX, OP_SW, OP_SB, OP_SH:
				return 1'b0;
			// no multiplier or divider
			OP_ALU:
				return (sub == ALU_MUL) || (sub == ALU_MULU) ||
					(sub == ALU_DIV) || (sub == ALU_DIVU);
			default:
				return 1'b1;
		endcase
	endfunction

	function automatic reg_addr_t dest_of(word_t insn);
		if (insn[31:26] == OP_JAL || insn[31:26] == OP_JALR)
			return LINK_REG;
		return insn[25:21];
	endfunction

	// EX destination as the DUT should present it and zero on a bubble
	function automatic reg_addr_t ex_dest();
		return m_ex_valid ? dest_of(m_ex_insn) : 5'd0;
	endfunction

	function automatic logic ex_writes();
		return m_ex_valid && wb_we_of(m_ex_insn);
	endfunction

	function automatic sel_e forward_sel(reg_addr_t src, logic use_imm);
		if (use_imm)
			return SEL_IMM;
		if (src == ex_dest() && ex_writes())
			return SEL_EX_FORW;
		if (src == m_wb_addrw && wbforw_valid)
			return SEL_WB_FORW;
		return SEL_RF;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// reference model and checks on the rising edge
	////////////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin : ref_model
		logic flush;
		logic bubble;
		flush = except_flushpipe || pc_we || extend_flush;
		bubble = (!ex_freeze && id_freeze) || flush;
		if (rst) begin
			m_id_insn <= NOP_INSN;
			m_ex_insn <= NOP_INSN;
			m_wb_insn <= NOP_INSN;
			m_ex_valid <= 1'b0;
			m_sel_imm <= 1'b0;
			m_ex_simm <= '0;
			m_ex_tgt <= '0;
			m_wb_addrw <= '0;
		end else begin
			if (flush)
				m_id_insn <= NOP_INSN;
			else if (!id_freeze)
				m_id_insn <= if_insn;
			// sel_imm ignores flush
			if (!id_freeze)
				m_sel_imm <= predecode_sel_imm(if_insn);
			if (bubble) begin
				m_ex_insn <= NOP_INSN;
				m_ex_valid <= 1'b0;
			end else if (!ex_freeze) begin
				m_ex_insn <= m_id_insn;
				m_ex_valid <= 1'b1;
			end
			if (!ex_freeze) begin
				m_ex_simm <= extend_imm(m_id_insn);
				m_ex_tgt <= branch_target(m_id_insn, id_pc);
			end
			if (!wb_freeze) begin
				m_wb_insn <= m_ex_insn;
				m_wb_addrw <= ex_dest();
			end
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_val(input string sig, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		assert (act_v === exp_v)
			else fail_run($sformatf("mismatch %s %s: expected %h actual %h",
				test_name, sig, exp_v, act_v));
	endtask

	task automatic check_outputs();
		word_t ex;
		logic  v;
		ex = m_ex_insn;
		v = m_ex_valid;
		check_val("flushpipe", except_flushpipe || pc_we || extend_flush, flushpipe);
		check_val("rf_addra", if_insn[20:16], rf_addra);
		check_val("rf_addrb", if_insn[15:11], rf_addrb);
		check_val("id_insn", m_id_insn, id_insn);
		check_val("ex_insn", m_ex_insn, ex_insn);
		check_val("wb_insn", m_wb_insn, wb_insn);
		// ID side
		check_val("id_branch_op", predecode_branch(m_id_insn), id_branch_op);
		check_val("id_lsu_op", lsu_of(m_id_insn), id_lsu_op);
		check_val("id_simm", extend_imm(m_id_insn), id_simm);
		check_val("id_branch_addrtarget", branch_target(m_id_insn, id_pc),
			id_branch_addrtarget);
		check_val("sel_a", forward_sel(m_id_insn[20:16], 1'b0), sel_a);
		check_val("sel_b", forward_sel(m_id_insn[15:11], m_sel_imm), sel_b);
		// EX side goes inactive on a bubble
		check_val("ex_simm", m_ex_simm, ex_simm);
		check_val("ex_branch_addrtarget", m_ex_tgt, ex_branch_addrtarget);
		check_val("ex_branch_op", v ? predecode_branch(ex) : BR_NOP, ex_branch_op);
		check_val("alu_op", v ? alu_of(ex) : ALU_NOP, alu_op);
		check_val("alu_op2", v ? ex[9:6] : 4'h0, alu_op2);
		check_val("comp_op", v ? ex[24:21] : 4'h0, comp_op);
		check_val("rfwb_src", v ? wb_src_of(ex) : RFWB_ALU, rfwb_src);
		check_val("rfwb_we", ex_writes(), rfwb_we);
		check_val("rf_addrw", ex_dest(), rf_addrw);
		check_val("spr_read", v && ex[31:26] == OP_MFSPR, spr_read);
		check_val("spr_write", v && ex[31:26] == OP_MTSPR, spr_write);
		check_val("sig_syscall", v && ex[31:23] == {OP_XSYNC, 3'b000}, sig_syscall);
		check_val("sig_trap", v && ex[31:23] == {OP_XSYNC, 3'b010}, sig_trap);
		check_val("except_illegal", v && illegal_of(ex), except_illegal);
	endtask

	always @(posedge clk) begin : output_checks
		if (!rst) begin
			check_outputs();
		end
	end

	// run limit
	always @(posedge clk) begin : watchdog
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			fail_run("run exceeded the cycle limit without finishing");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus helpers
	////////////////////////////////////////////////////////////////////////////

	// 16-bit galois lfsr stepped once per bit
	function automatic logic lfsr_step();
		logic b;
		b = lfsr_q[0];
		lfsr_q = lfsr_q >> 1;
		if (b)
			lfsr_q = lfsr_q ^ 16'hb400;
		return b;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_step()};
		end
		return v;
	endfunction

	function automatic word_t mk_insn(logic [5:0] op, reg_addr_t rd, reg_addr_t ra,
			logic [15:0] low);
		return {op, rd, ra, low};
	endfunction

	// sub-op in [3:0] and rb in [15:11]
	function automatic word_t mk_alu(reg_addr_t rd, reg_addr_t ra, reg_addr_t rb,
			logic [3:0] sub);
		return mk_insn(OP_ALU, rd, ra, {rb, 1'b0, 4'h0, 2'b00, sub});
	endfunction

	// register fields kept narrow so dependencies show up
	function automatic word_t rand_insn();
		logic [31:0] r;
		logic [5:0]  op;
		reg_addr_t   rd;
		reg_addr_t   ra;
		reg_addr_t   rb;
		r = rand_bits(6);
		op = r[5:0];
		r = rand_bits(4);
		rd = {r[3], 1'b0, r[2:0]};
		r = rand_bits(3);
		ra = {2'b00, r[2:0]};
		r = rand_bits(4);
		rb = {r[3], 1'b0, r[2:0]};
		r = rand_bits(11);
		return {op, rd, ra, rb, r[10:0]};
	endfunction

	// inputs change on the falling edge only
	task automatic drive(input word_t insn, input logic [2:0] frz, input logic [2:0] fl,
			input logic wbv, input word_t pc);
		@(negedge clk);
		if_insn = insn;
		{id_freeze, ex_freeze, wb_freeze} = frz;
		{except_flushpipe, pc_we, extend_flush} = fl;
		wbforw_valid = wbv;
		id_pc = pc;
	endtask

	task automatic issue(input word_t insn);
		drive(insn, 3'b000, 3'b000, 1'b0, 32'h0000_1000);
	endtask

	task automatic random_cycle();
		word_t       insn;
		logic [2:0]  frz;
		logic [2:0]  fl;
		logic [31:0] r;
		insn = rand_insn();
		// each freeze about one cycle in four
		for (int k = 0; k < 3; k++) begin
			r = rand_bits(2);
			frz[k] = (r[1:0] == 2'b00);
		end
		// each flush source about one cycle in sixteen
		for (int k = 0; k < 3; k++) begin
			r = rand_bits(4);
			fl[k] = (r[3:0] == 4'h0);
		end
		r = rand_bits(1);
		drive(insn, frz, fl, r[0], rand_bits(32));
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin : stimulus
		word_t fwd_seq [5];
		clk = 1'b0;
		rst = 1'b1;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		wb_freeze = 1'b0;
		except_flushpipe = 1'b0;
		pc_we = 1'b0;
		extend_flush = 1'b0;
		wbforw_valid = 1'b0;
		if_insn = NOP_INSN;
		id_pc = '0;
		lfsr_q = 16'd59074;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		// plain flow through ID, EX and WB
		test_name = "latency";
		issue(mk_insn(OP_ADDI, 5'd3, 5'd1, 16'h0005));
		issue(mk_insn(OP_JAL, 5'd0, 5'd0, 16'h0040));
		issue(mk_insn(OP_LWZ, 5'd4, 5'd2, 16'h0010));
		issue(mk_insn(OP_MOVHI, 5'd5, 5'd0, 16'h1234));
		repeat (4) issue(NOP_INSN);

		// one pass per flush source
		test_name = "flush";
		for (int s = 0; s < 3; s++) begin
			issue(mk_insn(OP_ADDI, 5'd6, 5'd1, 16'h0001));
			issue(mk_insn(OP_BF, 5'd0, 5'd0, 16'h0008));
			drive(mk_insn(OP_SFXXI, 5'd2, 5'd6, 16'h0003), 3'b000, 3'b100 >> s, 1'b0,
				32'h0000_2000);
			issue(NOP_INSN);
			issue(NOP_INSN);
		end

		// bubble then full and partial holds
		test_name = "freeze";
		issue(mk_insn(OP_ORI, 5'd7, 5'd2, 16'h00ff));
		issue(mk_insn(OP_JR, 5'd0, 5'd0, 16'h4800));
		drive(mk_insn(OP_ANDI, 5'd8, 5'd1, 16'h0f0f), 3'b100, 3'b000, 1'b0, 32'h100);
		drive(mk_insn(OP_XORI, 5'd9, 5'd3, 16'hf000), 3'b111, 3'b000, 1'b0, 32'h104);
		drive(mk_insn(OP_MFSPR, 5'd10, 5'd0, 16'h0011), 3'b110, 3'b000, 1'b0, 32'h108);
		drive(mk_insn(OP_MTSPR, 5'd1, 5'd2, 16'h0022), 3'b001, 3'b000, 1'b0, 32'h10c);
		drive(mk_insn(OP_LBS, 5'd11, 5'd2, 16'h8000), 3'b011, 3'b000, 1'b0, 32'h110);
		repeat (3) issue(NOP_INSN);

		// every major opcode then the alu sub-ops and xsync forms
		test_name = "decode";
		for (int op = 0; op < 64; op++) begin
			issue(mk_insn(op[5:0], 5'd7, 5'd1, 16'h8123));
		end
		for (int sub = 0; sub < 16; sub++) begin
			issue(mk_alu(5'd12, 5'd3, 5'd4, sub[3:0]));
		end
		// bit 4 lies above the sub-op and leaves l.mul illegal
		issue(mk_alu(5'd12, 5'd3, 5'd4, 4'h6) | 32'h0000_0010);
		issue(mk_insn(OP_XSYNC, 5'b00000, 5'd0, 16'h0001));
		issue(mk_insn(OP_XSYNC, 5'b01000, 5'd0, 16'h0002));
		issue(mk_insn(OP_XSYNC, 5'b11100, 5'd0, 16'h0000));
		repeat (2) issue(NOP_INSN);

		// each immediate class including negative offsets
		test_name = "immediates";
		drive(mk_insn(OP_ADDI, 5'd2, 5'd1, 16'hfff0), 3'b000, 3'b000, 1'b0, 32'h0001_0000);
		drive(mk_insn(OP_ANDI, 5'd2, 5'd1, 16'h8001), 3'b000, 3'b000, 1'b0, 32'h0001_0004);
		drive(mk_insn(OP_SW, 5'b10000, 5'd1, 16'h0404), 3'b000, 3'b000, 1'b0, 32'h0001_0008);
		drive(mk_insn(OP_MTSPR, 5'b10001, 5'd1, 16'h07ff), 3'b000, 3'b000, 1'b0, 32'h0c);
		drive(mk_insn(OP_J, 5'b11111, 5'b11111, 16'hfffe), 3'b000, 3'b000, 1'b0, 32'h0000_0010);
		drive(mk_insn(OP_BNF, 5'b00000, 5'd0, 16'h0100), 3'b000, 3'b000, 1'b0, 32'hffff_fff0);
		drive(mk_insn(OP_LHS, 5'd3, 5'd2, 16'h8002), 3'b000, 3'b000, 1'b0, 32'h0000_0020);
		repeat (3) issue(NOP_INSN);

		// back-to-back dependencies with wbforw_valid steady then toggling
		test_name = "forwarding";
		fwd_seq[0] = mk_insn(OP_ADDI, 5'd3, 5'd1, 16'h0005);
		fwd_seq[1] = mk_alu(5'd4, 5'd3, 5'd3, 4'h0);
		fwd_seq[2] = mk_alu(5'd5, 5'd3, 5'd4, 4'h0);
		fwd_seq[3] = mk_insn(OP_ORI, 5'd6, 5'd4, 16'h0005);
		fwd_seq[4] = mk_alu(5'd7, 5'd5, 5'd6, 4'h2);
		for (int w = 0; w < 3; w++) begin
			for (int k = 0; k < 5; k++) begin
				drive(fwd_seq[k], 3'b000, 3'b000, (w == 1) || (w == 2 && k[0]),
					32'h0000_3000);
			end
			issue(NOP_INSN);
		end

		test_name = "random";
		repeat (RAND_CYCLES) random_cycle();
		repeat (4) issue(NOP_INSN);
		@(posedge clk);
		@(negedge clk);
		$display("Test OK");
		$finish;
	end

endmodule

// ==== sources.f ====
hdl/decode_pkg.sv
hdl/insn_pipe.sv
hdl/if_predecode.sv
hdl/imm_branch_gen.sv
hdl/ex_ctrl_decode.sv
hdl/operand_fwd.sv
hdl/ctrl_top.sv
dv/tb_ctrl.sv

// ==== Bender.yml ====
package:
  name: ctrl_decode

sources:
  - hdl/decode_pkg.sv
  - hdl/insn_pipe.sv
  - hdl/if_predecode.sv
  - hdl/imm_branch_gen.sv
  - hdl/ex_ctrl_decode.sv
  - hdl/operand_fwd.sv
  - hdl/ctrl_top.sv
  - target: test
    files:
      - dv/tb_ctrl.sv
